// ==== hw/sa_pkg.sv ====
//////////////////////////////////////////////////
// Fixed 8x8 engine. T is 1 to 8, and 0 is not supported
// Score and output widths hold the worst-case 8-bit products
//////////////////////////////////////////////////
package sa_pkg;

	localparam int DIM        = 8;
	localparam int IDX_W      = 3;
	localparam int ROWS_W     = 4;
	localparam int DATA_W     = 8;
	localparam int QKV_W      = 19;
	localparam int SCORE_W    = 41;
	localparam int OUT_W      = 64;
	localparam int ROWS_RESET = 8;
	localparam int SCORE_DIV  = 3;

	// Element types, all two's complement
	typedef logic signed [DATA_W-1:0]  data_t;
	typedef logic signed [QKV_W-1:0]   qkv_t;
	typedef logic signed [SCORE_W-1:0] score_t;
	typedef logic signed [OUT_W-1:0]   out_t;

	// Counters and row count
	typedef logic [IDX_W-1:0]  idx_t;
	typedef logic [ROWS_W-1:0] rows_t;

	// Job phases, each load phase is 64 cycles
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOAD_Q,
		PH_LOAD_K,
		PH_LOAD_V,
		PH_OUTPUT
	} phase_e;

endpackage

// ==== hw/sa_ctrl_if.sv ====
//////////////////////////////////////////////////
// All signals are registered in the controller
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface sa_ctrl_if;
	import sa_pkg::*;

	phase_e phase;
	idx_t   row;
	idx_t   col;
	// Current X element is in a row below T
	logic   x_write;

	modport ctrl (
		output phase, row, col, x_write
	);

	modport dp (
		input phase, row, col, x_write
	);

endinterface

// ==== hw/sa_ctrl.sv ====
//////////////////////////////////////////////////
// t_rows is taken only on the first in_valid cycle while idle
// No handshake. A job runs to its end once started
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_ctrl (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_valid,
	input  sa_pkg::rows_t t_rows,
	sa_ctrl_if.ctrl       ctl
);
	import sa_pkg::*;

	phase_e phase_nxt;
	idx_t   row_nxt;
	idx_t   col_nxt;
	rows_t  t_reg;
	rows_t  t_nxt;
	logic   col_last;
	logic   row_last;
	logic   mat_last;

	// Output phase stops after T rows, load phases after 8
	assign col_last = (ctl.col == idx_t'(DIM - 1));
	assign row_last = (ctl.phase == PH_OUTPUT) ? (rows_t'(ctl.row) == rows_t'(t_reg - 1'b1))
	                                           : (ctl.row == idx_t'(DIM - 1));
	assign mat_last = col_last && row_last;

	assign t_nxt = (ctl.phase == PH_IDLE && in_valid) ? t_rows : t_reg;

	// Next phase is the look-ahead; registered it lines up with staged inputs
	always_comb begin
		phase_nxt = ctl.phase;
		case (ctl.phase)
			PH_IDLE:   if (in_valid) phase_nxt = PH_LOAD_Q;
			PH_LOAD_Q: if (mat_last) phase_nxt = PH_LOAD_K;
			PH_LOAD_K: if (mat_last) phase_nxt = PH_LOAD_V;
			PH_LOAD_V: if (mat_last) phase_nxt = PH_OUTPUT;
			PH_OUTPUT: if (mat_last) phase_nxt = PH_IDLE;
		endcase
	end

	// Row/column walk, held at origin while idle
	always_comb begin
		col_nxt = '0;
		row_nxt = '0;
		if (ctl.phase != PH_IDLE) begin
			col_nxt = col_last ? '0 : ctl.col + 1'b1;
			row_nxt = ctl.row;
			if (col_last) begin
				row_nxt = row_last ? '0 : ctl.row + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctl.phase   <= PH_IDLE;
			ctl.row     <= '0;
			ctl.col     <= '0;
			ctl.x_write <= 1'b1;
			t_reg       <= rows_t'(ROWS_RESET);
		end else begin
			ctl.phase   <= phase_nxt;
			ctl.row     <= row_nxt;
			ctl.col     <= col_nxt;
			ctl.x_write <= (rows_t'(row_nxt) < t_nxt);
			t_reg       <= t_nxt;
		end
	end

endmodule

// ==== hw/sa_matrix_buf.sv ====
//////////////////////////////////////////////////
// Priority is clear, then write, then column add
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_matrix_buf #(
	parameter type elem_t = logic
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         clear,
	input  logic         we,
	input  sa_pkg::idx_t row,
	input  sa_pkg::idx_t col,
	input  elem_t        wdata,
	input  logic         col_acc,
	input  elem_t        acc_in [sa_pkg::DIM],
	output elem_t        mat    [sa_pkg::DIM][sa_pkg::DIM]
);
	import sa_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DIM; i++) begin
				for (int j = 0; j < DIM; j++) begin
					mat[i][j] <= '0;
				end
			end
		end else if (clear) begin
			for (int i = 0; i < DIM; i++) begin
				for (int j = 0; j < DIM; j++) begin
					mat[i][j] <= '0;
				end
			end
		end else if (we) begin
			mat[row][col] <= wdata;
		end else if (col_acc) begin
			// One partial product per row, all into the same column
			for (int i = 0; i < DIM; i++) begin
				mat[i][col] <= mat[i][col] + acc_in[i];
			end
		end
	end

endmodule

// ==== hw/sa_dot8.sv ====
//////////////////////////////////////////////////
// Purely combinational. Products wrap at 64 bits
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_dot8 (
	input  sa_pkg::score_t a [sa_pkg::DIM],
	input  sa_pkg::score_t b [sa_pkg::DIM],
	output sa_pkg::out_t   sum
);
	import sa_pkg::*;

	out_t prod   [DIM];
	out_t sum_l1 [DIM/2];
	out_t sum_l2 [DIM/4];

	always_comb begin
		// Widen before multiplying so the sign carries through
		for (int i = 0; i < DIM; i++) begin
			prod[i] = out_t'(a[i]) * out_t'(b[i]);
		end
		for (int i = 0; i < DIM/2; i++) begin
			sum_l1[i] = prod[2*i] + prod[2*i+1];
		end
		for (int i = 0; i < DIM/4; i++) begin
			sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
		end
	end

	assign sum = sum_l2[0] + sum_l2[1];

endmodule

// ==== hw/sa_datapath.sv ====
//////////////////////////////////////////////////
// Inputs are sampled every cycle and used one cycle later
// out_data is zero whenever out_valid is low
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_datapath (
	input  logic          clk,
	input  logic          rst_n,
	input  sa_pkg::data_t in_data,
	input  sa_pkg::data_t w_q,
	input  sa_pkg::data_t w_k,
	input  sa_pkg::data_t w_v,
	sa_ctrl_if.dp         ctl,
	output logic          out_valid,
	output sa_pkg::out_t  out_data
);
	import sa_pkg::*;

	data_t  x_stage, wq_stage, wk_stage, wv_stage;
	data_t  w_sel;
	data_t  x_mat [DIM][DIM];
	data_t  wq_mat [DIM][DIM];
	qkv_t   q_mat [DIM][DIM];
	qkv_t   k_mat [DIM][DIM];
	qkv_t   v_mat [DIM][DIM];
	score_t s_mat [DIM][DIM];
	qkv_t   mac [DIM];
	data_t  zero_d [DIM];
	qkv_t   zero_q [DIM];
	score_t zero_s [DIM];
	score_t dot_a [DIM];
	score_t dot_b [DIM];
	out_t   dot_sum;
	qkv_t   q_wdata;
	score_t s_wdata;
	logic   ph_idle, ph_load_q, ph_load_k, ph_load_v, ph_out;

	assign ph_idle   = (ctl.phase == PH_IDLE);
	assign ph_load_q = (ctl.phase == PH_LOAD_Q);
	assign ph_load_k = (ctl.phase == PH_LOAD_K);
	assign ph_load_v = (ctl.phase == PH_LOAD_V);
	assign ph_out    = (ctl.phase == PH_OUTPUT);

	always_ff @(posedge clk) begin
		x_stage  <= in_data;
		wq_stage <= w_q;
		wk_stage <= w_k;
		wv_stage <= w_v;
	end

	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			zero_d[i] = '0;
			zero_q[i] = '0;
			zero_s[i] = '0;
		end
	end

	// Column MAC: K or V column gets X[*][row] times one weight
	always_comb begin
		w_sel = ph_load_v ? wv_stage : wk_stage;
		for (int i = 0; i < DIM; i++) begin
			mac[i] = qkv_t'(x_mat[i][ctl.row]) * qkv_t'(w_sel);
		end
	end

	// Dot operands by phase
	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			dot_a[i] = '0;
			dot_b[i] = '0;
			if (ph_load_k) begin
				dot_a[i] = score_t'(x_mat[ctl.row][i]);
				dot_b[i] = score_t'(wq_mat[i][ctl.col]);
			end else if (ph_load_v) begin
				dot_a[i] = score_t'(q_mat[ctl.row][i]);
				dot_b[i] = score_t'(k_mat[ctl.col][i]);
			end else if (ph_out) begin
				dot_a[i] = s_mat[ctl.row][i];
				dot_b[i] = score_t'(v_mat[i][ctl.col]);
			end
		end
	end

	sa_dot8 u_dot (.a(dot_a), .b(dot_b), .sum(dot_sum));

	assign q_wdata = qkv_t'(dot_sum);
	// ReLU then truncating divide
	assign s_wdata = (dot_sum < 0) ? '0 : score_t'(dot_sum / SCORE_DIV);

	sa_matrix_buf #(.elem_t(data_t)) u_x (
		.clk, .rst_n, .clear(ph_out), .we(ph_load_q && ctl.x_write),
		.row(ctl.row), .col(ctl.col), .wdata(x_stage),
		.col_acc(1'b0), .acc_in(zero_d), .mat(x_mat)
	);
	sa_matrix_buf #(.elem_t(data_t)) u_wq (
		.clk, .rst_n, .clear(1'b0), .we(ph_load_q),
		.row(ctl.row), .col(ctl.col), .wdata(wq_stage),
		.col_acc(1'b0), .acc_in(zero_d), .mat(wq_mat)
	);
	sa_matrix_buf #(.elem_t(qkv_t)) u_q (
		.clk, .rst_n, .clear(ph_idle), .we(ph_load_k),
		.row(ctl.row), .col(ctl.col), .wdata(q_wdata),
		.col_acc(1'b0), .acc_in(zero_q), .mat(q_mat)
	);
	sa_matrix_buf #(.elem_t(qkv_t)) u_k (
		.clk, .rst_n, .clear(ph_idle), .we(1'b0),
		.row(ctl.row), .col(ctl.col), .wdata('0),
		.col_acc(ph_load_k), .acc_in(mac), .mat(k_mat)
	);
	sa_matrix_buf #(.elem_t(qkv_t)) u_v (
		.clk, .rst_n, .clear(ph_idle), .we(1'b0),
		.row(ctl.row), .col(ctl.col), .wdata('0),
		.col_acc(ph_load_v), .acc_in(mac), .mat(v_mat)
	);
	sa_matrix_buf #(.elem_t(score_t)) u_s (
		.clk, .rst_n, .clear(ph_idle), .we(ph_load_v),
		.row(ctl.row), .col(ctl.col), .wdata(s_wdata),
		.col_acc(1'b0), .acc_in(zero_s), .mat(s_mat)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else begin
			out_valid <= ph_out;
			out_data  <= ph_out ? dot_sum : '0;
		end
	end

endmodule

// ==== hw/sa_top.sv ====
//////////////////////////////////////////////////
// in_valid must stay high 192 cycles; no back-pressure
// Outputs appear T*8 cycles, row-major, 3 edges after input
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_top (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_valid,
	input  sa_pkg::rows_t t_rows,
	input  sa_pkg::data_t in_data,
	input  sa_pkg::data_t w_q,
	input  sa_pkg::data_t w_k,
	input  sa_pkg::data_t w_v,
	output logic          out_valid,
	output sa_pkg::out_t  out_data
);

	// Phase and matrix position from controller to datapath
	sa_ctrl_if ctl_if ();

	sa_ctrl u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.t_rows   (t_rows),
		.ctl      (ctl_if.ctrl)
	);

	sa_datapath u_dp (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (in_data),
		.w_q       (w_q),
		.w_k       (w_k),
		.w_v       (w_v),
		.ctl       (ctl_if.dp),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// ==== verif/sa_assert.sv ====
//////////////////////////////////////////////////
// Bound to sa_top, checks output framing only
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_assert (
	input logic         clk,
	input logic         rst_n,
	input logic         in_valid,
	input logic         out_valid,
	input sa_pkg::out_t out_data
);

	// Output bus is quiet between results
	a_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0)
		else $error("out_data is nonzero while out_valid is low");

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid && out_valid))
		else $error("out_valid and in_valid are high together");

	// Fixed latency from end of input to first result
	a_rise_after_input: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(in_valid) |-> ##2 $rose(out_valid))
		else $error("out_valid did not rise two cycles after in_valid fell");

	a_valid_min_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |=> out_valid)
		else $error("out_valid dropped after a single cycle");

endmodule

bind sa_top sa_assert u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_data  (out_data)
);

// ==== verif/sa_tb.sv ====
//////////////////////////////////////////////////
// Jobs run back to back, each starts after out_valid falls
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sa_tb;
	import sa_pkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int RISE_LIMIT    = 16;
	localparam int MODE_RANDOM   = 0;
	localparam int MODE_POSITIVE = 1;
	localparam int MODE_NEG_KEYS = 2;
	localparam int NUM_JOBS      = 7;
	// Job table: row count and fill mode
	localparam int JOB_T [NUM_JOBS]    = '{8, 1, 8, 3, 5, 8, 2};
	localparam int JOB_MODE [NUM_JOBS] = '{MODE_RANDOM, MODE_RANDOM, MODE_NEG_KEYS,
		MODE_POSITIVE, MODE_RANDOM, MODE_POSITIVE, MODE_NEG_KEYS};

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	rows_t t_rows;
	data_t in_data, w_q, w_k, w_v;
	logic  out_valid;
	out_t  out_data;

	data_t       x_m [DIM][DIM];
	data_t       wq_m [DIM][DIM];
	data_t       wk_m [DIM][DIM];
	data_t       wv_m [DIM][DIM];
	longint      exp_out [DIM][DIM];
	logic [15:0] lfsr;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          cycle_cnt = 0;
	int          timeout_cycles = 0;

	sa_top dut0 (.clk, .rst_n, .in_valid, .t_rows, .in_data, .w_q, .w_k, .w_v,
		.out_valid, .out_data);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fill_matrices(input int mode);
		for (int i = 0; i < DIM; i++) begin
			for (int k = 0; k < DIM; k++) begin
				if (mode == MODE_RANDOM) begin
					x_m[i][k]  = data_t'(take_bits(8));
					wq_m[i][k] = data_t'(take_bits(8));
					wk_m[i][k] = data_t'(take_bits(8));
					wv_m[i][k] = data_t'(take_bits(8));
				end else begin
					x_m[i][k]  = data_t'(take_bits(7));
					wq_m[i][k] = data_t'(take_bits(7));
					wk_m[i][k] = data_t'(take_bits(7));
					wv_m[i][k] = data_t'(take_bits(7));
					// Q stays positive and K negative, so every score is negative
					if (mode == MODE_NEG_KEYS) wk_m[i][k] = -wk_m[i][k];
				end
			end
		end
	endtask

	task automatic compute_expected(input int t);
		longint q [DIM][DIM];
		longint k [DIM][DIM];
		longint v [DIM][DIM];
		longint s [DIM][DIM];
		for (int i = 0; i < DIM; i++) begin
			for (int c = 0; c < DIM; c++) begin
				q[i][c] = 0;
				k[i][c] = 0;
				v[i][c] = 0;
				// X rows at T and above count as zero
				for (int m = 0; m < DIM; m++) begin
					if (i < t) begin
						q[i][c] += longint'(x_m[i][m]) * longint'(wq_m[m][c]);
						k[i][c] += longint'(x_m[i][m]) * longint'(wk_m[m][c]);
						v[i][c] += longint'(x_m[i][m]) * longint'(wv_m[m][c]);
					end
				end
			end
		end
		for (int i = 0; i < DIM; i++) begin
			for (int c = 0; c < DIM; c++) begin
				s[i][c] = 0;
				for (int m = 0; m < DIM; m++) s[i][c] += q[i][m] * k[c][m];
				s[i][c] = (s[i][c] < 0) ? 0 : s[i][c] / 3;
			end
		end
		for (int i = 0; i < DIM; i++) begin
			for (int c = 0; c < DIM; c++) begin
				exp_out[i][c] = 0;
				for (int m = 0; m < DIM; m++) exp_out[i][c] += s[i][m] * v[m][c];
			end
		end
	endtask

	task automatic send_inputs(input int t);
		int r;
		int k;
		for (int c = 0; c < 3 * DIM * DIM; c++) begin
			r = (c % (DIM * DIM)) / DIM;
			k = c % DIM;
			@(posedge clk);
			in_valid <= 1'b1;
			t_rows   <= rows_t'(t);
			in_data  <= (c < 64) ? x_m[r][k] : '0;
			w_q      <= (c < 64) ? wq_m[r][k] : '0;
			w_k      <= (c / 64 == 1) ? wk_m[r][k] : '0;
			w_v      <= (c / 64 == 2) ? wv_m[r][k] : '0;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		t_rows   <= '0;
		in_data  <= '0;
		w_q      <= '0;
		w_k      <= '0;
		w_v      <= '0;
	endtask

	task automatic check_outputs(input int t);
		int edges;
		edges = 0;
		// The edge that ended the input counts as the first
		do begin
			@(negedge clk);
			edges++;
		end while (!out_valid && edges < RISE_LIMIT);
		assert (out_valid === 1'b1) else begin
			$display("out_valid never rose after the input ended");
			err_cnt++;
		end
		if (out_valid !== 1'b1) return;
		assert (edges == 3) else begin
			$display("FAIL out_valid rise edge: expected %h, got %h", 3, edges);
			err_cnt++;
		end
		for (int n = 0; n < t * DIM; n++) begin
			if (n > 0) @(negedge clk);
			check_cnt++;
			assert (out_valid === 1'b1) else begin
				$display("FAIL out_valid at output %0d: expected %h, got %h", n, 1'b1, out_valid);
				err_cnt++;
			end
			assert (out_data === out_t'(exp_out[n / DIM][n % DIM])) else begin
				$display("FAIL out_data[%0d][%0d]: expected %h, got %h", n / DIM, n % DIM,
					out_t'(exp_out[n / DIM][n % DIM]), out_data);
				err_cnt++;
			end
		end
		@(negedge clk);
		assert (out_valid === 1'b0) else begin
			$display("FAIL out_valid after last output: expected %h, got %h", 1'b0, out_valid);
			err_cnt++;
		end
	endtask

	initial begin
		int err_before;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		t_rows   = '0;
		in_data  = '0;
		w_q      = '0;
		w_k      = '0;
		w_v      = '0;
		lfsr     = 16'd16329;
		timeout_cycles = RESET_CYCLES;
		for (int j = 0; j < NUM_JOBS; j++) timeout_cycles += 192 + JOB_T[j] * 8 + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (out_valid === 1'b0 && out_data === '0) else begin
			$display("FAIL out_valid/out_data after reset: expected %h/%h, got %h/%h",
				1'b0, 64'h0, out_valid, out_data);
			err_cnt++;
		end
		for (int j = 0; j < NUM_JOBS; j++) begin
			err_before = err_cnt;
			fill_matrices(JOB_MODE[j]);
			compute_expected(JOB_T[j]);
			send_inputs(JOB_T[j]);
			check_outputs(JOB_T[j]);
			$display("Job %0d T=%0d mode=%0d: %0d errors", j, JOB_T[j], JOB_MODE[j],
				err_cnt - err_before);
		end
		$display("Jobs %0d, output checks %0d, errors %0d", NUM_JOBS, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== sa_top.f ====
hw/sa_pkg.sv
hw/sa_ctrl_if.sv
hw/sa_ctrl.sv
hw/sa_matrix_buf.sv
hw/sa_dot8.sv
hw/sa_datapath.sv
hw/sa_top.sv
verif/sa_assert.sv
verif/sa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the attention engine testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module sa_tb -f sa_top.f -o sa_tb_sim
status=0
./obj_dir/sa_tb_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ] || ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
